// File: uart_slave.f
+incdir+tests
design/slave_cfg_pkg.sv
design/slave_proto_pkg.sv
design/control_decoder.sv
design/write_shifter.sv
design/read_shifter.sv
design/ack_tracker.sv
design/slave_ctrl.sv
design/uart_slave.sv
tests/tb_uart_slave.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uart_slave testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f uart_slave.f --top-module tb_uart_slave -o tb_uart_slave > build.log 2>&1 \
    && ./obj_dir/tb_uart_slave > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: tests/tb_uart_slave_tasks.svh
`ifndef TB_UART_SLAVE_TASKS_SVH
`define TB_UART_SLAVE_TASKS_SVH

// start code 111, slave id, r/w bit, msb first
task automatic send_frame(input logic [S_ID_WIDTH-1:0] id, input logic write);
    logic [CON_BITS-1:0] frame;
    frame = {3'b111, id, write};
    for (int i = CON_BITS - 1; i >= 0; i--) begin
        @(posedge clk);
        control <= frame[i];
    end
    @(posedge clk);
    control <= 1'b0;
    // frame decode and state change
    @(posedge clk);
endtask

// an idle cycle with a wrong bit ahead of every byte but the first
task automatic shift_word(input logic [DATA_WIDTH-1:0] word);
    for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
        if (i % 8 == 7 && i != DATA_WIDTH - 1) begin
            @(posedge clk);
            valid <= 1'b0;
            wD    <= ~word[i];
        end
        @(posedge clk);
        valid <= 1'b1;
        wD    <= word[i];
    end
    @(posedge clk);
    valid <= 1'b0;
    wD    <= 1'b0;
endtask

task automatic wait_tx_start(input bit get_side, input int limit);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
        @(negedge clk);
        seen = get_side ? g_txStart : s_txStart;
        n++;
    end
    assert (seen) else begin
        other_errors++;
        $display("%s-side transmitter was never started", get_side ? "get" : "send");
    end
endtask

task automatic wait_ready(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!ready && n < limit) begin
        @(negedge clk);
        n++;
    end
    assert (ready) else begin
        other_errors++;
        $display("ready did not return high within %0d cycles", limit);
    end
endtask

task automatic write_word(input logic [DATA_WIDTH-1:0] word);
    @(posedge clk);
    s_txReady <= 1'b0;
    pulse_mark = tx_pulses;
    send_frame(S_ID_WIDTH'(SLAVE_ID), 1'b1);
    @(negedge clk);
    check_value("ready", ready, 1'b1);
    shift_word(word);
    // transmitter still busy
    repeat (3) begin
        @(negedge clk);
        check_value("ready", ready, 1'b0);
        check_value("s_txStart", s_txStart, 1'b0);
    end
    @(posedge clk);
    s_txReady <= 1'b1;
    wait_tx_start(1'b0, 8);
    check_value("s_byteForTx", s_byteForTx, word);
endtask

task automatic answer_ack(input logic [DATA_WIDTH-1:0] ack_word);
    repeat (4) @(posedge clk);
    s_rxDone     <= 1'b1;
    s_byteFromRx <= ack_word;
    @(posedge clk);
    s_rxDone     <= 1'b0;
    s_byteFromRx <= '0;
    wait_ready(ACK_TIMEOUT);
endtask

task automatic read_word(input logic [DATA_WIDTH-1:0] word,
                         input logic [STATUS_BITS-1:0] status);
    logic [READ_BITS-1:0] bits;
    int                   high_cycles;
    bits        = '0;
    high_cycles = 0;
    send_frame(S_ID_WIDTH'(SLAVE_ID), 1'b0);
    @(negedge clk);
    check_value("ready", ready, 1'b0);
    @(posedge clk);
    g_rxDone     <= 1'b1;
    g_byteFromRx <= word;
    @(posedge clk);
    g_rxDone     <= 1'b0;
    g_byteFromRx <= '0;
    // one cycle of get-side back-pressure
    @(posedge clk);
    g_txReady <= 1'b1;
    wait_tx_start(1'b1, 8);
    check_value("g_byteForTx", g_byteForTx, ACK_WORD);
    for (int i = 0; i < READ_BITS; i++) begin
        @(negedge clk);
        bits = {bits[READ_BITS-2:0], rD};
        if (ready) begin
            high_cycles++;
        end
    end
    check_value("ready high cycles", high_cycles, READ_BITS);
    check_value("rD", bits, {status, word});
    @(negedge clk);
    check_value("ready", ready, 1'b0);
    @(negedge clk);
    check_value("ready", ready, 1'b1);
    @(posedge clk);
    g_txReady <= 1'b0;
endtask

// frame for the next id, write data must be ignored
task automatic reject_foreign_frame(input logic [DATA_WIDTH-1:0] held_word);
    logic [DATA_WIDTH-1:0] word;
    int                    low_cycles;
    low_cycles = 0;
    @(posedge clk);
    s_txReady <= 1'b1;
    pulse_mark = tx_pulses;
    send_frame(S_ID_WIDTH'(SLAVE_ID + 1), 1'b1);
    random_word(word);
    shift_word(word);
    repeat (ACK_TIMEOUT) begin
        @(negedge clk);
        if (!ready) begin
            low_cycles++;
        end
    end
    check_value("ready low cycles", low_cycles, 0);
    check_value("s_txStart pulses", tx_pulses - pulse_mark, 0);
    check_value("s_byteForTx", s_byteForTx, held_word);
endtask

`endif

// File: tests/tb_uart_slave.sv
`timescale 1ns/100ps

module tb_uart_slave;
    import slave_cfg_pkg::*;

    localparam int CYCLE_LIMIT = 3000;
    localparam int READ_BITS   = STATUS_BITS + DATA_WIDTH;
    // acknowledge bytes as the uart receivers deliver them
    localparam logic [DATA_WIDTH-1:0]  ACK_WORD = 32'h0000_00cc;
    localparam logic [DATA_WIDTH-1:0]  NAK_WORD = 32'h0000_00aa;
    // upper nibble of each acknowledge byte
    localparam logic [STATUS_BITS-1:0] ST_ACK   = 4'b1100;
    localparam logic [STATUS_BITS-1:0] ST_NAK   = 4'b1010;

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  control;
    logic                  wD;
    logic                  valid;
    logic                  rD;
    logic                  ready;
    logic                  g_txStart;
    logic [DATA_WIDTH-1:0] g_byteForTx;
    logic                  g_txReady;
    logic                  g_rxDone;
    logic [DATA_WIDTH-1:0] g_byteFromRx;
    logic                  s_txStart;
    logic [DATA_WIDTH-1:0] s_byteForTx;
    logic                  s_txReady;
    logic                  s_rxDone;
    logic [DATA_WIDTH-1:0] s_byteFromRx;

    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count  = 0;
    int          tx_pulses    = 0;
    int          pulse_mark   = 0;
    logic [31:0] lfsr_state   = 32'h8208f4fc;

    uart_slave DUT (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .wD          (wD),
        .valid       (valid),
        .rD          (rD),
        .ready       (ready),
        .g_txStart   (g_txStart),
        .g_byteForTx (g_byteForTx),
        .g_txReady   (g_txReady),
        .g_rxDone    (g_rxDone),
        .g_byteFromRx(g_byteFromRx),
        .s_txStart   (s_txStart),
        .s_byteForTx (s_byteForTx),
        .s_txReady   (s_txReady),
        .s_rxDone    (s_rxDone),
        .s_byteFromRx(s_byteFromRx)
    );

    always #10 clk = ~clk;

    // send-side transmitter starts, one per cycle high
    always @(negedge clk) begin
        if (s_txStart) begin
            tx_pulses++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped at cycle %0d before the tests finished", cycle_count);
            $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [DATA_WIDTH-1:0] w);
        w = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[DATA_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    `include "tb_uart_slave_tasks.svh"

    initial begin
        logic [DATA_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0] sent;
        rstN         = 1'b0;
        control      = 1'b0;
        wD           = 1'b0;
        valid        = 1'b0;
        g_txReady    = 1'b0;
        g_rxDone     = 1'b0;
        g_byteFromRx = '0;
        s_txReady    = 1'b0;
        s_rxDone     = 1'b0;
        s_byteFromRx = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check_value("ready", ready, 1'b1);
        check_value("s_txStart", s_txStart, 1'b0);
        check_value("g_txStart", g_txStart, 1'b0);
        check_value("rD", rD, 1'b0);
        check_value("s_byteForTx", s_byteForTx, '0);
        check_value("g_byteForTx", g_byteForTx, '0);
        random_word(word);
        read_word(word, 4'b0000);

        // no answer, every retransmission times out
        random_word(sent);
        write_word(sent);
        wait_ready(4 * ACK_TIMEOUT);
        check_value("s_txStart pulses", tx_pulses - pulse_mark, 1 + RETRANSMIT_TIMES);
        random_word(word);
        read_word(word, ST_NAK);

        random_word(sent);
        write_word(sent);
        answer_ack(ACK_WORD);
        check_value("s_txStart pulses", tx_pulses - pulse_mark, 1);
        random_word(word);
        read_word(word, ST_ACK);

        // status survives a frame for another node
        reject_foreign_frame(sent);
        random_word(word);
        read_word(word, ST_ACK);

        random_word(sent);
        write_word(sent);
        answer_ack(NAK_WORD);
        check_value("s_txStart pulses", tx_pulses - pulse_mark, 1);
        random_word(word);
        read_word(word, ST_NAK);

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/uart_slave.sv
`timescale 1ns/100ps

module uart_slave (
    input  logic                                 clk,
    input  logic                                 rstN,
    // master side
    input  logic                                 control,
    input  logic                                 wD,
    input  logic                                 valid,
    output logic                                 rD,
    output logic                                 ready,
    // get-side uart
    output logic                                 g_txStart,
    output logic [slave_cfg_pkg::DATA_WIDTH-1:0] g_byteForTx,
    input  logic                                 g_txReady,
    input  logic                                 g_rxDone,
    input  logic [slave_cfg_pkg::DATA_WIDTH-1:0] g_byteFromRx,
    // send-side uart
    output logic                                 s_txStart,
    output logic [slave_cfg_pkg::DATA_WIDTH-1:0] s_byteForTx,
    input  logic                                 s_txReady,
    input  logic                                 s_rxDone,
    input  logic [slave_cfg_pkg::DATA_WIDTH-1:0] s_byteFromRx
);
    import slave_cfg_pkg::*;

    logic                   frame_start;
    logic                   frame_done;
    logic                   frame_match;
    logic                   frame_write;
    logic                   shift_en;
    logic                   word_full;
    logic                   tx_fire;
    logic                   resend_req;
    logic                   ack_done;
    logic [STATUS_BITS-1:0] status;
    logic                   rd_load;
    logic                   rd_start;
    logic                   shift_busy;
    logic                   shift_done;

    control_decoder u_decoder (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .frame_start(frame_start),
        .frame_done (frame_done),
        .frame_match(frame_match),
        .frame_write(frame_write)
    );

    write_shifter #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_write (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (shift_en),
        .wD       (wD),
        .word_full(word_full),
        .word     (s_byteForTx)
    );

    read_shifter u_read (
        .clk    (clk),
        .rstN   (rstN),
        .load   (rd_load),
        .word_in(g_byteFromRx),
        .status (status),
        .start  (rd_start),
        .rD     (rD),
        .busy   (shift_busy),
        .done   (shift_done)
    );

    ack_tracker u_ack (
        .clk       (clk),
        .rstN      (rstN),
        .tx_fire   (tx_fire),
        .ack_valid (s_rxDone),
        .ack_byte  (s_byteFromRx),
        .resend_req(resend_req),
        .ack_done  (ack_done),
        .status    (status)
    );

    slave_ctrl u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .valid      (valid),
        .frame_done (frame_done),
        .frame_match(frame_match),
        .frame_write(frame_write),
        .word_full  (word_full),
        .resend_req (resend_req),
        .ack_done   (ack_done),
        .s_txReady  (s_txReady),
        .g_txReady  (g_txReady),
        .g_rxDone   (g_rxDone),
        .shift_busy (shift_busy),
        .shift_done (shift_done),
        .frame_start(frame_start),
        .shift_en   (shift_en),
        .tx_fire    (tx_fire),
        .rd_load    (rd_load),
        .rd_start   (rd_start),
        .s_txStart  (s_txStart),
        .g_txStart  (g_txStart),
        .ready      (ready),
        .g_byteForTx(g_byteForTx)
    );

endmodule

// File: design/slave_ctrl.sv
`timescale 1ns/100ps

module slave_ctrl (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 control,
    input  logic                                 valid,
    input  logic                                 frame_done,
    input  logic                                 frame_match,
    input  logic                                 frame_write,
    input  logic                                 word_full,
    input  logic                                 resend_req,
    input  logic                                 ack_done,
    input  logic                                 s_txReady,
    input  logic                                 g_txReady,
    input  logic                                 g_rxDone,
    input  logic                                 shift_busy,
    input  logic                                 shift_done,
    output logic                                 frame_start,
    output logic                                 shift_en,
    output logic                                 tx_fire,
    output logic                                 rd_load,
    output logic                                 rd_start,
    output logic                                 s_txStart,
    output logic                                 g_txStart,
    output logic                                 ready,
    output logic [slave_cfg_pkg::DATA_WIDTH-1:0] g_byteForTx
);
    import slave_cfg_pkg::*;
    import slave_proto_pkg::*;

    slave_state_e state;
    slave_state_e state_next;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:     if (control) state_next = FRAME;
            FRAME: begin
                if (frame_done) begin
                    if (!frame_match) begin
                        state_next = IDLE;
                    end else if (frame_write) begin
                        state_next = WRITE;
                    end else begin
                        state_next = GET_WAIT;
                    end
                end
            end
            WRITE:    if (word_full) state_next = TX_WAIT;
            TX_WAIT:  if (s_txReady) state_next = ACK_WAIT;
            ACK_WAIT: begin
                if (ack_done) begin
                    state_next = IDLE;
                end else if (resend_req) begin
                    state_next = TX_WAIT;
                end
            end
            GET_WAIT: if (g_rxDone) state_next = GET_ACK;
            GET_ACK:  if (g_txReady) state_next = READ_OUT;
            READ_OUT: if (shift_done) state_next = IDLE;
            default:  state_next = IDLE;
        endcase
    end

    // strobes last one cycle since the state moves on
    assign frame_start = (state == IDLE) && control;
    assign shift_en    = (state == WRITE) && valid;
    assign tx_fire     = (state == TX_WAIT) && s_txReady;
    assign s_txStart   = tx_fire;
    assign rd_load     = (state == GET_WAIT) && g_rxDone;
    assign g_txStart   = (state == GET_ACK) && g_txReady;
    assign rd_start    = g_txStart;

    always_comb begin
        case (state)
            IDLE, FRAME: ready = 1'b1;
            WRITE:       ready = !word_full;
            READ_OUT:    ready = shift_busy;
            default:     ready = 1'b0;
        endcase
    end

    // ack byte back to the previous board
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            g_byteForTx <= '0;
        end else if (rd_load) begin
            g_byteForTx <= {{(DATA_WIDTH - ACK_BYTE_WIDTH){1'b0}}, ACK};
        end
    end

endmodule

// File: design/ack_tracker.sv
`timescale 1ns/100ps

module ack_tracker (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  tx_fire,
    input  logic                                  ack_valid,
    input  logic [slave_cfg_pkg::DATA_WIDTH-1:0]  ack_byte,
    output logic                                  resend_req,
    output logic                                  ack_done,
    output logic [slave_cfg_pkg::STATUS_BITS-1:0] status
);
    import slave_cfg_pkg::*;
    import slave_proto_pkg::*;

    localparam int WAIT_W  = $clog2(ACK_TIMEOUT);
    localparam int RETRY_W = $clog2(RETRANSMIT_TIMES + 1);

    localparam logic [ACK_BYTE_WIDTH-1:0] ACK_VAL    = ACK;
    localparam logic [ACK_BYTE_WIDTH-1:0] NAK_VAL    = NAK;
    localparam logic [STATUS_BITS-1:0]    ACK_NIBBLE = ACK_VAL[ACK_BYTE_WIDTH-1 -: STATUS_BITS];
    localparam logic [STATUS_BITS-1:0]    NAK_NIBBLE = NAK_VAL[ACK_BYTE_WIDTH-1 -: STATUS_BITS];

    logic               armed;
    logic [WAIT_W-1:0]  wait_cnt;
    logic [RETRY_W-1:0] retry_cnt;
    logic               ack_match;
    logic               timed_out;

    // receiver word is the ack byte zero extended
    assign ack_match = (ack_byte == {{(DATA_WIDTH - ACK_BYTE_WIDTH){1'b0}}, ACK_VAL});
    assign timed_out = (wait_cnt == WAIT_W'(ACK_TIMEOUT - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            armed      <= 1'b0;
            wait_cnt   <= '0;
            retry_cnt  <= '0;
            resend_req <= 1'b0;
            ack_done   <= 1'b0;
            status     <= STATUS_NONE;
        end else begin
            resend_req <= 1'b0;
            ack_done   <= 1'b0;
            if (tx_fire) begin
                // every transmission restarts the timeout
                armed    <= 1'b1;
                wait_cnt <= '0;
            end else if (armed) begin
                if (ack_valid) begin
                    status    <= ack_match ? ACK_NIBBLE : NAK_NIBBLE;
                    ack_done  <= 1'b1;
                    armed     <= 1'b0;
                    retry_cnt <= '0;
                end else if (timed_out) begin
                    armed <= 1'b0;
                    if (retry_cnt == RETRY_W'(RETRANSMIT_TIMES)) begin
                        // retries used up, no answer means NAK
                        status    <= NAK_NIBBLE;
                        ack_done  <= 1'b1;
                        retry_cnt <= '0;
                    end else begin
                        retry_cnt  <= retry_cnt + 1'b1;
                        resend_req <= 1'b1;
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/read_shifter.sv
`timescale 1ns/100ps

module read_shifter (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  load,
    input  logic [slave_cfg_pkg::DATA_WIDTH-1:0]  word_in,
    input  logic [slave_cfg_pkg::STATUS_BITS-1:0] status,
    input  logic                                  start,
    output logic                                  rD,
    output logic                                  busy,
    output logic                                  done
);
    import slave_cfg_pkg::*;

    localparam int TOTAL = STATUS_BITS + DATA_WIDTH;
    localparam int CNT_W = $clog2(TOTAL);

    logic [DATA_WIDTH-1:0] word_q;
    logic [TOTAL-1:0]      shift_q;
    logic [CNT_W-1:0]      bit_cnt;

    // word from the get-side receiver
    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= word_in;
        end
    end

    // status nibble goes out ahead of the word
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= {status, word_q};
        end else if (busy) begin
            shift_q <= shift_q << 1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                if (bit_cnt == CNT_W'(TOTAL - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    assign rD = busy & shift_q[TOTAL-1];

endmodule

// File: design/write_shifter.sv
`timescale 1ns/100ps

module write_shifter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  shift_en,
    input  logic                  wD,
    output logic                  word_full,
    output logic [DATA_WIDTH-1:0] word
);

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    logic [CNT_W-1:0] bit_cnt;

    assign word_full = (bit_cnt == CNT_W'(DATA_WIDTH));

    // msb arrives first, word stays put once full
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt <= '0;
            word    <= '0;
        end else if (shift_en && !word_full) begin
            word    <= {word[DATA_WIDTH-2:0], wD};
            bit_cnt <= bit_cnt + 1'b1;
        end else if (!shift_en && word_full) begin
            // word handed off, ready for the next write
            bit_cnt <= '0;
        end
    end

endmodule

// File: design/control_decoder.sv
`timescale 1ns/100ps

module control_decoder (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic frame_start,
    output logic frame_done,
    output logic frame_match,
    output logic frame_write
);
    import slave_cfg_pkg::*;
    import slave_proto_pkg::*;

    localparam int CNT_W = $clog2(CON_BITS);

    logic [CON_BITS-1:0] frame_q;
    logic [CNT_W-1:0]    bit_cnt;
    logic                busy;
    control_code_e       frame_code;

    // frame register fills msb first
    always_ff @(posedge clk) begin
        if (frame_start || busy) begin
            frame_q <= {frame_q[CON_BITS-2:0], control};
        end
    end

    // first bit is taken together with frame_start
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy       <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(1);
            end else if (busy) begin
                if (bit_cnt == CNT_W'(CON_BITS - 1)) begin
                    busy       <= 1'b0;
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // start code | slave id | r/w
    assign frame_code  = control_code_e'(frame_q[CON_BITS-1 -: 3]);
    assign frame_match = (frame_code == START) &&
                         (frame_q[S_ID_WIDTH:1] == S_ID_WIDTH'(SLAVE_ID));
    assign frame_write = frame_q[0];

endmodule

// File: design/slave_proto_pkg.sv
package slave_proto_pkg;

    // start codes, only START opens a transfer
    typedef enum logic [2:0] {
        ABORT    = 3'b100,
        CONTINUE = 3'b101,
        HOLD     = 3'b110,
        START    = 3'b111
    } control_code_e;

    typedef enum logic [7:0] {
        ACK = 8'b11001100,
        NAK = 8'b10101010
    } ack_code_e;

    typedef enum logic [2:0] {
        IDLE,
        FRAME,
        WRITE,
        TX_WAIT,
        ACK_WAIT,
        GET_WAIT,
        GET_ACK,
        READ_OUT
    } slave_state_e;

    localparam logic [3:0] STATUS_NONE = 4'b0000;

endpackage

// File: design/slave_cfg_pkg.sv
package slave_cfg_pkg;

    // word and frame sizes
    localparam int DATA_WIDTH     = 32;
    localparam int SLAVES         = 3;
    localparam int S_ID_WIDTH     = $clog2(SLAVES);
    localparam int SLAVE_ID       = 1;
    // start code, slave id, r/w bit
    localparam int CON_BITS       = 3 + S_ID_WIDTH + 1;
    localparam int STATUS_BITS    = 4;
    localparam int ACK_BYTE_WIDTH = 8;

    // acknowledge timing on the send side
    localparam int ACK_TIMEOUT      = 50;
    localparam int RETRANSMIT_TIMES = 2;

endpackage
